//--- files.f
source/dmac_bus_pkg.sv
source/dmac_reg_pkg.sv
source/dmac_ifs.sv
source/ctrl_router.sv
source/dma_regs.sv
source/beat_counter.sv
source/dma_fsm.sv
source/dma_channel.sv
source/mem_arbiter.sv
source/dmac_per_wrap.sv
tb/tb_dmac.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the DMA testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --top-module tb_dmac -f files.f -o sim_dmac

./obj_dir/sim_dmac | tee sim.log

if grep -q "^TESTS PASSED$" sim.log; then
   echo "simulation result: pass"
   exit 0
else
   echo "simulation result: fail"
   exit 1
fi

//--- source/beat_counter.sv
`timescale 1ns/1ns

module beat_counter (
   input  logic                           clk_dma_i,
   input  logic                           rst_i,
   input  logic                           load_i,
   input  logic                           step_i,
   input  logic [dmac_reg_pkg::LEN_W-1:0] len_i,
   output dmac_bus_pkg::addr_t            offset_o,
   output logic                           last_o,
   output logic                           empty_o
);

   logic [dmac_reg_pkg::LEN_W-1:0] remain_q;
   dmac_bus_pkg::addr_t            offset_q;

   always_ff @(posedge clk_dma_i)
   begin
      if (rst_i)
      begin
         remain_q <= '0;
         offset_q <= '0;
      end
      else if (load_i)
      begin
         remain_q <= len_i;
         offset_q <= '0;
      end
      else if (step_i)
      begin
         // one beat written, move to the next one
         remain_q <= remain_q - 1;
         offset_q <= offset_q + dmac_bus_pkg::BEAT_BYTES;
      end
   end

   assign offset_o = offset_q;
   assign last_o   = (remain_q == 1);
   assign empty_o  = (remain_q == 0);

endmodule

//--- source/ctrl_router.sv
`timescale 1ns/1ns

module ctrl_router (
   input  logic                clk_dma_i,
   input  logic                rst_i,
   input  logic                ctrl_req_i,
   input  logic                ctrl_wen_i,
   input  dmac_bus_pkg::addr_t ctrl_add_i,
   input  dmac_bus_pkg::data_t ctrl_wdata_i,
   output logic                ctrl_gnt_o,
   output logic                ctrl_r_valid_o,
   output dmac_bus_pkg::data_t ctrl_r_rdata_o,
   dmac_reg_if.router          reg_bus [dmac_reg_pkg::NB_CHAN-1:0]
);

   logic                    in_range;
   dmac_reg_pkg::chan_sel_t chan_sel;
   dmac_reg_pkg::chan_sel_t rd_chan_q;
   logic                    rd_oor_q;
   dmac_bus_pkg::data_t     chan_rdata [dmac_reg_pkg::NB_CHAN];

   // target never stalls
   assign ctrl_gnt_o = ctrl_req_i;

   assign in_range = ctrl_add_i < (dmac_bus_pkg::addr_t'(dmac_reg_pkg::NB_CHAN)
                                   * dmac_reg_pkg::CHAN_STRIDE);
   assign chan_sel = ctrl_add_i[$clog2(dmac_reg_pkg::CHAN_STRIDE)];

   for (genvar c = 0; c < dmac_reg_pkg::NB_CHAN; c++)
   begin : g_chan
      logic hit;

      assign hit               = ctrl_req_i & in_range
                                 & (chan_sel == dmac_reg_pkg::chan_sel_t'(c));
      assign reg_bus[c].we     = hit & ~ctrl_wen_i;
      assign reg_bus[c].re     = hit & ctrl_wen_i;
      assign reg_bus[c].offset = ctrl_add_i[5:2];
      assign reg_bus[c].wdata  = ctrl_wdata_i;
      assign chan_rdata[c]     = reg_bus[c].rdata;
   end

   // read response one cycle after the grant
   always_ff @(posedge clk_dma_i)
   begin
      if (rst_i)
      begin
         ctrl_r_valid_o <= 1'b0;
         rd_chan_q      <= '0;
         rd_oor_q       <= 1'b0;
      end
      else
      begin
         ctrl_r_valid_o <= ctrl_req_i & ctrl_wen_i;
         if (ctrl_req_i && ctrl_wen_i)
         begin
            rd_chan_q <= chan_sel;
            rd_oor_q  <= ~in_range;
         end
      end
   end

   // out of range reads come back as zero
   assign ctrl_r_rdata_o = rd_oor_q ? '0 : chan_rdata[rd_chan_q];

endmodule

//--- source/dma_channel.sv
`timescale 1ns/1ns

module dma_channel (
   input  logic          clk_dma_i,
   input  logic          rst_i,
   dmac_reg_if.regs      reg_bus,
   dmac_mem_if.initiator mem
);

   dmac_bus_pkg::addr_t     src;
   dmac_bus_pkg::addr_t     dst;
   dmac_bus_pkg::addr_t     offset;
   dmac_reg_pkg::cmd_word_u cmd;
   dmac_bus_pkg::beat_t     beat_q;
   logic                    start;
   logic                    load;
   logic                    step;
   logic                    capture;
   logic                    done;
   logic                    rd_req;
   logic                    wr_req;
   logic                    last;
   logic                    empty;

   dma_regs u_regs (
      .clk_dma_i         (clk_dma_i),
      .rst_i             (rst_i),
      .reg_bus           (reg_bus),
      .last_write_done_i (done),
      .src_o             (src),
      .dst_o             (dst),
      .cmd_o             (cmd),
      .start_o           (start)
   );

   beat_counter u_count (
      .clk_dma_i (clk_dma_i),
      .rst_i     (rst_i),
      .load_i    (load),
      .step_i    (step),
      .len_i     (cmd.fields.len),
      .offset_o  (offset),
      .last_o    (last),
      .empty_o   (empty)
   );

   dma_fsm u_fsm (
      .clk_dma_i     (clk_dma_i),
      .rst_i         (rst_i),
      .start_i       (start),
      .empty_i       (empty),
      .last_i        (last),
      .mem_gnt_i     (mem.gnt),
      .mem_r_valid_i (mem.r_valid),
      .rd_req_o      (rd_req),
      .wr_req_o      (wr_req),
      .load_o        (load),
      .step_o        (step),
      .capture_o     (capture),
      .done_o        (done)
   );

   // beat buffer between the read and the write
   always_ff @(posedge clk_dma_i)
   begin
      if (capture)
         beat_q <= mem.r_rdata;
   end

   assign mem.req   = rd_req | wr_req;
   assign mem.wen   = rd_req;
   assign mem.add   = rd_req ? (src + offset) : (dst + offset);
   assign mem.wdata = beat_q;

endmodule

//--- source/dma_fsm.sv
`timescale 1ns/1ns

module dma_fsm (
   input  logic clk_dma_i,
   input  logic rst_i,
   input  logic start_i,
   input  logic empty_i,
   input  logic last_i,
   input  logic mem_gnt_i,
   input  logic mem_r_valid_i,
   output logic rd_req_o,
   output logic wr_req_o,
   output logic load_o,
   output logic step_o,
   output logic capture_o,
   output logic done_o
);

   logic [2:0] state_q;
   logic [2:0] state_d;

   always_ff @(posedge clk_dma_i)
   begin
      if (rst_i)
         state_q <= dmac_reg_pkg::ST_IDLE;
      else
         state_q <= state_d;
   end

   // requests depend on the state only, never on the grant
   assign rd_req_o = (state_q == dmac_reg_pkg::ST_READ) & ~empty_i;
   assign wr_req_o = (state_q == dmac_reg_pkg::ST_WRITE);

   always_comb
   begin
      state_d   = state_q;
      load_o    = 1'b0;
      step_o    = 1'b0;
      capture_o = 1'b0;
      done_o    = 1'b0;
      case (state_q)
         dmac_reg_pkg::ST_IDLE:
         begin
            if (start_i)
            begin
               load_o  = 1'b1;
               state_d = dmac_reg_pkg::ST_READ;
            end
         end
         dmac_reg_pkg::ST_READ:
         begin
            // zero length finishes without touching memory
            if (empty_i)
            begin
               done_o  = 1'b1;
               state_d = dmac_reg_pkg::ST_FINISH;
            end
            else if (mem_gnt_i)
               state_d = dmac_reg_pkg::ST_WAIT_DATA;
         end
         dmac_reg_pkg::ST_WAIT_DATA:
         begin
            if (mem_r_valid_i)
            begin
               capture_o = 1'b1;
               state_d   = dmac_reg_pkg::ST_WRITE;
            end
         end
         dmac_reg_pkg::ST_WRITE:
         begin
            if (mem_gnt_i)
            begin
               step_o = 1'b1;
               if (last_i)
               begin
                  done_o  = 1'b1;
                  state_d = dmac_reg_pkg::ST_FINISH;
               end
               else
                  state_d = dmac_reg_pkg::ST_READ;
            end
         end
         // status settles here before a new start
         dmac_reg_pkg::ST_FINISH: state_d = dmac_reg_pkg::ST_IDLE;
         default: state_d = dmac_reg_pkg::ST_IDLE;
      endcase
   end

endmodule

//--- source/dma_regs.sv
`timescale 1ns/1ns

module dma_regs (
   input  logic                    clk_dma_i,
   input  logic                    rst_i,
   dmac_reg_if.regs                reg_bus,
   input  logic                    last_write_done_i,
   output dmac_bus_pkg::addr_t     src_o,
   output dmac_bus_pkg::addr_t     dst_o,
   output dmac_reg_pkg::cmd_word_u cmd_o,
   output logic                    start_o
);

   dmac_bus_pkg::addr_t     src_q;
   dmac_bus_pkg::addr_t     dst_q;
   dmac_reg_pkg::cmd_word_u cmd_q;
   dmac_reg_pkg::cmd_word_u cmd_wr;
   logic                    busy_q;
   logic                    done_q;
   logic                    start_q;
   logic [3:0]              rd_off_q;

   assign cmd_wr.raw = reg_bus.wdata;

   always_ff @(posedge clk_dma_i)
   begin
      if (rst_i)
      begin
         src_q    <= '0;
         dst_q    <= '0;
         cmd_q    <= '0;
         busy_q   <= 1'b0;
         done_q   <= 1'b0;
         start_q  <= 1'b0;
         rd_off_q <= '0;
      end
      else
      begin
         start_q <= 1'b0;
         if (reg_bus.re)
            rd_off_q <= reg_bus.offset;
         if (reg_bus.we)
         begin
            case ({reg_bus.offset, 2'b00})
               dmac_reg_pkg::REG_SRC: src_q <= reg_bus.wdata;
               dmac_reg_pkg::REG_DST: dst_q <= reg_bus.wdata;
               dmac_reg_pkg::REG_CMD:
               begin
                  // a running copy keeps its command
                  if (!busy_q)
                  begin
                     cmd_q <= cmd_wr;
                     if (cmd_wr.fields.start)
                     begin
                        start_q <= 1'b1;
                        busy_q  <= 1'b1;
                        done_q  <= 1'b0;
                     end
                  end
               end
               default: ;
            endcase
         end
         if (last_write_done_i)
         begin
            busy_q <= 1'b0;
            done_q <= 1'b1;
         end
      end
   end

   // read-back word for the offset latched by the last read
   always_comb
   begin
      reg_bus.rdata = '0;
      case ({rd_off_q, 2'b00})
         dmac_reg_pkg::REG_SRC:    reg_bus.rdata = src_q;
         dmac_reg_pkg::REG_DST:    reg_bus.rdata = dst_q;
         dmac_reg_pkg::REG_CMD:    reg_bus.rdata = cmd_q.raw;
         dmac_reg_pkg::REG_STATUS: reg_bus.rdata[1:0] = {done_q, busy_q};
         default: ;
      endcase
   end

   assign src_o   = src_q;
   assign dst_o   = dst_q;
   assign cmd_o   = cmd_q;
   assign start_o = start_q;

endmodule

//--- source/dmac_bus_pkg.sv
package dmac_bus_pkg;

   // control word and byte address widths
   localparam int DATA_W = 32;
   localparam int ADDR_W = 32;

   // one memory beat holds two control-width lanes
   localparam int BEAT_W = 2 * DATA_W;

   typedef logic [DATA_W-1:0] data_t;
   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [BEAT_W-1:0] beat_t;

   // address step per beat
   localparam addr_t BEAT_BYTES = addr_t'(BEAT_W / 8);

endpackage

//--- source/dmac_ifs.sv
`timescale 1ns/1ns

//************************************************************
// memory initiator bus with req/gnt/r_valid
//************************************************************
interface dmac_mem_if;
   logic                req;
   // high means read
   logic                wen;
   dmac_bus_pkg::addr_t add;
   dmac_bus_pkg::beat_t wdata;
   logic                gnt;
   logic                r_valid;
   dmac_bus_pkg::beat_t r_rdata;

   modport initiator (
      output req, wen, add, wdata,
      input  gnt, r_valid, r_rdata
   );

   modport target (
      input  req, wen, add, wdata,
      output gnt, r_valid, r_rdata
   );
endinterface

//************************************************************
// register access strobes from the router to one channel
//************************************************************
interface dmac_reg_if;
   logic                we;
   logic                re;
   // word offset inside the channel block
   logic [3:0]          offset;
   dmac_bus_pkg::data_t wdata;
   dmac_bus_pkg::data_t rdata;

   modport router (output we, re, offset, wdata, input rdata);
   modport regs   (input we, re, offset, wdata, output rdata);
endinterface

//--- source/dmac_per_wrap.sv
`timescale 1ns/1ns

module dmac_per_wrap (
   input  logic                clk_dma_i,
   input  logic                rst_i,

   // control target
   input  logic                ctrl_req_i,
   input  logic                ctrl_wen_i,
   input  dmac_bus_pkg::addr_t ctrl_add_i,
   input  dmac_bus_pkg::data_t ctrl_wdata_i,
   output logic                ctrl_gnt_o,
   output logic                ctrl_r_valid_o,
   output dmac_bus_pkg::data_t ctrl_r_rdata_o,

   // memory initiator
   output logic                mem_req_o,
   output logic                mem_wen_o,
   output dmac_bus_pkg::addr_t mem_add_o,
   output dmac_bus_pkg::beat_t mem_wdata_o,
   input  logic                mem_gnt_i,
   input  logic                mem_r_valid_i,
   input  dmac_bus_pkg::beat_t mem_r_rdata_i
);

   dmac_reg_if reg_bus [dmac_reg_pkg::NB_CHAN-1:0] ();
   dmac_mem_if mem_bus [dmac_reg_pkg::NB_CHAN-1:0] ();

   //************************************************************
   // control decode
   //************************************************************
   ctrl_router u_router (
      .clk_dma_i      (clk_dma_i),
      .rst_i          (rst_i),
      .ctrl_req_i     (ctrl_req_i),
      .ctrl_wen_i     (ctrl_wen_i),
      .ctrl_add_i     (ctrl_add_i),
      .ctrl_wdata_i   (ctrl_wdata_i),
      .ctrl_gnt_o     (ctrl_gnt_o),
      .ctrl_r_valid_o (ctrl_r_valid_o),
      .ctrl_r_rdata_o (ctrl_r_rdata_o),
      .reg_bus        (reg_bus)
   );

   //************************************************************
   // channels and memory port sharing
   //************************************************************
   for (genvar c = 0; c < dmac_reg_pkg::NB_CHAN; c++)
   begin : g_chan
      dma_channel u_chan (
         .clk_dma_i (clk_dma_i),
         .rst_i     (rst_i),
         .reg_bus   (reg_bus[c]),
         .mem       (mem_bus[c])
      );
   end

   mem_arbiter u_arb (
      .clk_dma_i     (clk_dma_i),
      .rst_i         (rst_i),
      .chan          (mem_bus),
      .mem_req_o     (mem_req_o),
      .mem_wen_o     (mem_wen_o),
      .mem_add_o     (mem_add_o),
      .mem_wdata_o   (mem_wdata_o),
      .mem_gnt_i     (mem_gnt_i),
      .mem_r_valid_i (mem_r_valid_i),
      .mem_r_rdata_i (mem_r_rdata_i)
   );

endmodule

//--- source/dmac_reg_pkg.sv
package dmac_reg_pkg;

   localparam int NB_CHAN = 2;

   // byte distance between channel register blocks
   localparam dmac_bus_pkg::addr_t CHAN_STRIDE = 32'h100;

   // register byte offsets inside one block
   localparam logic [5:0] REG_SRC    = 6'd0;
   localparam logic [5:0] REG_DST    = 6'd4;
   localparam logic [5:0] REG_CMD    = 6'd8;
   localparam logic [5:0] REG_STATUS = 6'd12;

   localparam int LEN_W = 16;

   // engine state codes
   localparam logic [2:0] ST_IDLE      = 3'd0;
   localparam logic [2:0] ST_READ      = 3'd1;
   localparam logic [2:0] ST_WAIT_DATA = 3'd2;
   localparam logic [2:0] ST_WRITE     = 3'd3;
   localparam logic [2:0] ST_FINISH    = 3'd4;

   typedef struct packed {
      logic [dmac_bus_pkg::DATA_W-LEN_W-2:0] reserved;
      logic                                  start;
      logic [LEN_W-1:0]                      len;
   } cmd_fields_t;

   // command word, kept raw in the register file
   typedef union packed {
      dmac_bus_pkg::data_t raw;
      cmd_fields_t         fields;
   } cmd_word_u;

   typedef logic chan_sel_t;

endpackage

//--- source/mem_arbiter.sv
`timescale 1ns/1ns

module mem_arbiter (
   input  logic                clk_dma_i,
   input  logic                rst_i,
   dmac_mem_if.target          chan [dmac_reg_pkg::NB_CHAN-1:0],
   output logic                mem_req_o,
   output logic                mem_wen_o,
   output dmac_bus_pkg::addr_t mem_add_o,
   output dmac_bus_pkg::beat_t mem_wdata_o,
   input  logic                mem_gnt_i,
   input  logic                mem_r_valid_i,
   input  dmac_bus_pkg::beat_t mem_r_rdata_i
);

   logic [dmac_reg_pkg::NB_CHAN-1:0] req;
   logic [dmac_reg_pkg::NB_CHAN-1:0] wen;
   dmac_bus_pkg::addr_t              add   [dmac_reg_pkg::NB_CHAN];
   dmac_bus_pkg::beat_t              wdata [dmac_reg_pkg::NB_CHAN];
   dmac_reg_pkg::chan_sel_t          prio_q;
   dmac_reg_pkg::chan_sel_t          sel_q;
   dmac_reg_pkg::chan_sel_t          rr_pick;
   dmac_reg_pkg::chan_sel_t          pick;
   logic                             hold_q;
   logic                             rd_pend_q;
   dmac_reg_pkg::chan_sel_t          rd_owner_q;

   // priority channel first, else the other one
   assign rr_pick = req[prio_q] ? prio_q : ~prio_q;
   // a waiting request keeps the port until granted
   assign pick    = hold_q ? sel_q : rr_pick;

   assign mem_req_o   = |req;
   assign mem_wen_o   = wen[pick];
   assign mem_add_o   = add[pick];
   assign mem_wdata_o = wdata[pick];

   for (genvar c = 0; c < dmac_reg_pkg::NB_CHAN; c++)
   begin : g_chan
      assign req[c]          = chan[c].req;
      assign wen[c]          = chan[c].wen;
      assign add[c]          = chan[c].add;
      assign wdata[c]        = chan[c].wdata;
      assign chan[c].gnt     = mem_gnt_i & req[c] & (pick == dmac_reg_pkg::chan_sel_t'(c));
      assign chan[c].r_valid = mem_r_valid_i & rd_pend_q
                               & (rd_owner_q == dmac_reg_pkg::chan_sel_t'(c));
      assign chan[c].r_rdata = mem_r_rdata_i;
   end

   always_ff @(posedge clk_dma_i)
   begin
      if (rst_i)
      begin
         prio_q     <= '0;
         sel_q      <= '0;
         hold_q     <= 1'b0;
         rd_pend_q  <= 1'b0;
         rd_owner_q <= '0;
      end
      else
      begin
         hold_q    <= mem_req_o & ~mem_gnt_i;
         sel_q     <= pick;
         rd_pend_q <= mem_req_o & mem_gnt_i & mem_wen_o;
         if (mem_req_o && mem_gnt_i)
         begin
            prio_q     <= ~pick;
            rd_owner_q <= pick;
         end
      end
   end

endmodule

//--- tb/tb_dmac.sv
`timescale 1ns/1ns

module tb_dmac;

   // 52 beats over all copies at up to 16 cycles each under random grants,
   // plus reset, register traffic, status polling and a wide margin
   localparam int MAX_CYCLES = 4000;
   // preloaded memory window 0x000 to 0xbff
   localparam int WIN_BEATS  = 384;

   logic                clk_dma_i = 1'b0;
   logic                rst_i;
   logic                ctrl_req_i;
   logic                ctrl_wen_i;
   dmac_bus_pkg::addr_t ctrl_add_i;
   dmac_bus_pkg::data_t ctrl_wdata_i;
   logic                ctrl_gnt_o;
   logic                ctrl_r_valid_o;
   dmac_bus_pkg::data_t ctrl_r_rdata_o;
   logic                mem_req_o;
   logic                mem_wen_o;
   dmac_bus_pkg::addr_t mem_add_o;
   dmac_bus_pkg::beat_t mem_wdata_o;
   logic                mem_gnt_i;
   logic                mem_r_valid_i;
   dmac_bus_pkg::beat_t mem_r_rdata_i;

   int cycle_count  = 0;
   int data_errors  = 0;
   int proto_errors = 0;
   int timeouts     = 0;

   // memory model state
   dmac_bus_pkg::beat_t mem_model [dmac_bus_pkg::addr_t];
   integer              seed = 32'h3e92;
   int                  rnd;
   logic                rd_pending = 1'b0;
   dmac_bus_pkg::addr_t rd_addr;
   logic                waiting = 1'b0;
   logic                hold_wen;
   dmac_bus_pkg::addr_t hold_add;
   dmac_bus_pkg::beat_t hold_wdata;
   dmac_bus_pkg::data_t req_cycles = '0;

   // copies started so far for the expected memory image
   dmac_bus_pkg::addr_t cp_src [$];
   dmac_bus_pkg::addr_t cp_dst [$];
   dmac_bus_pkg::addr_t cp_bytes [$];

   // pending comparisons for the checking process
   string               name_q [$];
   dmac_bus_pkg::beat_t exp_q [$];
   dmac_bus_pkg::beat_t act_q [$];
   time                 when_q [$];
   string               chk_name;
   dmac_bus_pkg::beat_t chk_exp;
   dmac_bus_pkg::beat_t chk_act;
   time                 chk_time;

   dmac_per_wrap u_dut (
      .clk_dma_i      (clk_dma_i),
      .rst_i          (rst_i),
      .ctrl_req_i     (ctrl_req_i),
      .ctrl_wen_i     (ctrl_wen_i),
      .ctrl_add_i     (ctrl_add_i),
      .ctrl_wdata_i   (ctrl_wdata_i),
      .ctrl_gnt_o     (ctrl_gnt_o),
      .ctrl_r_valid_o (ctrl_r_valid_o),
      .ctrl_r_rdata_o (ctrl_r_rdata_o),
      .mem_req_o      (mem_req_o),
      .mem_wen_o      (mem_wen_o),
      .mem_add_o      (mem_add_o),
      .mem_wdata_o    (mem_wdata_o),
      .mem_gnt_i      (mem_gnt_i),
      .mem_r_valid_i  (mem_r_valid_i),
      .mem_r_rdata_i  (mem_r_rdata_i)
   );

   always #10 clk_dma_i = ~clk_dma_i;

   always @(posedge clk_dma_i)
      cycle_count <= cycle_count + 1;

   //************************************************************
   // reference model
   //************************************************************
   // source beat pattern where both lanes depend on the whole address
   function automatic dmac_bus_pkg::beat_t exp_beat(input dmac_bus_pkg::addr_t a);
      return {a ^ 32'h3c3c_0f0f, (a * 32'h9e37_79b1) + 32'h1357_9bdf};
   endfunction

   // memory contents expected after all started copies
   function automatic dmac_bus_pkg::beat_t expected_at(input dmac_bus_pkg::addr_t a);
      dmac_bus_pkg::beat_t v;
      v = exp_beat(a);
      for (int k = 0; k < cp_dst.size(); k++)
      begin
         if (a >= cp_dst[k] && a < cp_dst[k] + cp_bytes[k])
            v = exp_beat(cp_src[k] + (a - cp_dst[k]));
      end
      return v;
   endfunction

   function automatic dmac_bus_pkg::addr_t reg_addr(input int chan, input logic [5:0] off);
      return dmac_bus_pkg::addr_t'(chan) * dmac_reg_pkg::CHAN_STRIDE
             + dmac_bus_pkg::addr_t'(off);
   endfunction

   // reserved 15 bits, start 1 bit, len 16 bits
   function automatic dmac_bus_pkg::data_t make_cmd(input logic [14:0] rsvd,
                                                    input logic start,
                                                    input logic [15:0] len);
      return {rsvd, start, len};
   endfunction

   //************************************************************
   // memory model answering on the falling edge
   //************************************************************
   initial
   begin : memory
      dmac_bus_pkg::addr_t a;
      mem_gnt_i     = 1'b0;
      mem_r_valid_i = 1'b0;
      mem_r_rdata_i = '0;
      for (int i = 0; i < WIN_BEATS; i++)
      begin
         a = dmac_bus_pkg::addr_t'(i) * dmac_bus_pkg::BEAT_BYTES;
         mem_model[a] = exp_beat(a);
      end
      forever
      begin
         @(negedge clk_dma_i);
         // read granted at the last edge
         mem_r_valid_i = rd_pending;
         mem_r_rdata_i = (rd_pending && mem_model.exists(rd_addr)) ? mem_model[rd_addr] : '0;
         rd_pending    = 1'b0;
         if (waiting)
         begin
            assert (mem_req_o === 1'b1)
            else
            begin
               proto_errors++;
               $display("Fail at %0t: mem_req_o expected 1, got %b", $time, mem_req_o);
            end
            assert (mem_add_o === hold_add)
            else
            begin
               proto_errors++;
               $display("Fail at %0t: mem_add_o expected %h, got %h", $time, hold_add,
                        mem_add_o);
            end
            assert (mem_wen_o === hold_wen)
            else
            begin
               proto_errors++;
               $display("Fail at %0t: mem_wen_o expected %b, got %b", $time, hold_wen,
                        mem_wen_o);
            end
            assert (mem_wdata_o === hold_wdata)
            else
            begin
               proto_errors++;
               $display("Fail at %0t: mem_wdata_o expected %h, got %h", $time, hold_wdata,
                        mem_wdata_o);
            end
         end
         mem_gnt_i = 1'b0;
         if (mem_req_o === 1'b1)
         begin
            req_cycles = req_cycles + 1;
            rnd        = $random(seed);
            mem_gnt_i  = rnd[3];
            if (mem_gnt_i)
            begin
               assert (mem_model.exists(mem_add_o))
               else
               begin
                  proto_errors++;
                  $display("memory access at %h is outside the preloaded window", mem_add_o);
               end
               if (mem_wen_o)
               begin
                  rd_pending = 1'b1;
                  rd_addr    = mem_add_o;
               end
               else
                  mem_model[mem_add_o] = mem_wdata_o;
            end
         end
         waiting    = (mem_req_o === 1'b1) && !mem_gnt_i;
         hold_wen   = mem_wen_o;
         hold_add   = mem_add_o;
         hold_wdata = mem_wdata_o;
      end
   end

   // checking process
   always @(negedge clk_dma_i)
   begin
      while (name_q.size() > 0)
      begin
         chk_name = name_q.pop_front();
         chk_exp  = exp_q.pop_front();
         chk_act  = act_q.pop_front();
         chk_time = when_q.pop_front();
         assert (chk_act === chk_exp)
         else
         begin
            data_errors++;
            $display("Fail at %0t: %s expected %h, got %h", chk_time, chk_name, chk_exp,
                     chk_act);
         end
      end
   end

   //************************************************************
   // control bus and check helpers
   //************************************************************
   task automatic compare_beat(input string name, input dmac_bus_pkg::beat_t exp,
                               input dmac_bus_pkg::beat_t act);
      name_q.push_back(name);
      exp_q.push_back(exp);
      act_q.push_back(act);
      when_q.push_back($time);
   endtask

   task automatic expect_word(input string name, input dmac_bus_pkg::data_t exp,
                              input dmac_bus_pkg::data_t act);
      compare_beat(name, {32'h0, exp}, {32'h0, act});
   endtask

   task automatic grant_seen();
      assert (ctrl_gnt_o === 1'b1)
      else
      begin
         proto_errors++;
         $display("Fail at %0t: ctrl_gnt_o expected 1, got %b", $time, ctrl_gnt_o);
      end
   endtask

   task automatic write_reg(input dmac_bus_pkg::addr_t addr, input dmac_bus_pkg::data_t data);
      @(negedge clk_dma_i);
      ctrl_req_i   = 1'b1;
      ctrl_wen_i   = 1'b0;
      ctrl_add_i   = addr;
      ctrl_wdata_i = data;
      @(posedge clk_dma_i);
      grant_seen();
      @(negedge clk_dma_i);
      ctrl_req_i = 1'b0;
   endtask

   task automatic read_reg(input dmac_bus_pkg::addr_t addr, output dmac_bus_pkg::data_t data);
      @(negedge clk_dma_i);
      ctrl_req_i = 1'b1;
      ctrl_wen_i = 1'b1;
      ctrl_add_i = addr;
      @(posedge clk_dma_i);
      grant_seen();
      @(negedge clk_dma_i);
      // response due one cycle after the grant
      assert (ctrl_r_valid_o === 1'b1)
      else
      begin
         proto_errors++;
         $display("Fail at %0t: ctrl_r_valid_o expected 1, got %b", $time, ctrl_r_valid_o);
      end
      data       = ctrl_r_rdata_o;
      ctrl_req_i = 1'b0;
   endtask

   task automatic verify_addr_regs();
      dmac_bus_pkg::data_t rdata;
      for (int c = 0; c < dmac_reg_pkg::NB_CHAN; c++)
      begin
         read_reg(reg_addr(c, dmac_reg_pkg::REG_SRC), rdata);
         expect_word($sformatf("ch%0d REG_SRC", c), 32'h5a00_0100 + dmac_bus_pkg::data_t'(c),
                     rdata);
         read_reg(reg_addr(c, dmac_reg_pkg::REG_DST), rdata);
         expect_word($sformatf("ch%0d REG_DST", c), 32'hc300_0200 + dmac_bus_pkg::data_t'(c),
                     rdata);
      end
   endtask

   task automatic start_copy(input int chan, input dmac_bus_pkg::addr_t src,
                             input dmac_bus_pkg::addr_t dst, input logic [15:0] len);
      cp_src.push_back(src);
      cp_dst.push_back(dst);
      cp_bytes.push_back(dmac_bus_pkg::addr_t'(len) * dmac_bus_pkg::BEAT_BYTES);
      write_reg(reg_addr(chan, dmac_reg_pkg::REG_SRC), src);
      write_reg(reg_addr(chan, dmac_reg_pkg::REG_DST), dst);
      write_reg(reg_addr(chan, dmac_reg_pkg::REG_CMD), make_cmd(15'h0, 1'b1, len));
   endtask

   // poll status until busy falls, then expect done with busy low
   task automatic wait_idle(input int chan);
      dmac_bus_pkg::data_t status;
      do
         read_reg(reg_addr(chan, dmac_reg_pkg::REG_STATUS), status);
      while (status[0] !== 1'b0);
      expect_word($sformatf("ch%0d REG_STATUS", chan), 32'h0000_0002, status);
   endtask

   task automatic scan_memory();
      dmac_bus_pkg::addr_t a;
      for (int i = 0; i < WIN_BEATS; i++)
      begin
         a = dmac_bus_pkg::addr_t'(i) * dmac_bus_pkg::BEAT_BYTES;
         compare_beat($sformatf("mem[%h]", a), expected_at(a), mem_model[a]);
      end
   endtask

   task automatic finish_run();
      $display("errors: data %0d, protocol %0d, timeout %0d", data_errors, proto_errors,
               timeouts);
      if (data_errors + proto_errors + timeouts == 0)
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   endtask

   //************************************************************
   // test sequence
   //************************************************************
   initial
   begin : stimulus
      dmac_bus_pkg::data_t rdata;
      dmac_bus_pkg::data_t req_before;
      ctrl_req_i   = 1'b0;
      ctrl_wen_i   = 1'b0;
      ctrl_add_i   = '0;
      ctrl_wdata_i = '0;
      rst_i        = 1'b1;
      repeat (10) @(negedge clk_dma_i);
      rst_i = 1'b0;

      // register read-back on both channels
      for (int c = 0; c < dmac_reg_pkg::NB_CHAN; c++)
      begin
         write_reg(reg_addr(c, dmac_reg_pkg::REG_SRC), 32'h5a00_0100 + dmac_bus_pkg::data_t'(c));
         write_reg(reg_addr(c, dmac_reg_pkg::REG_DST), 32'hc300_0200 + dmac_bus_pkg::data_t'(c));
      end
      verify_addr_regs();

      // out of range read gives zero and the write lands nowhere
      read_reg(reg_addr(2, dmac_reg_pkg::REG_SRC), rdata);
      expect_word("out of range ctrl_r_rdata_o", 32'h0, rdata);
      write_reg(reg_addr(2, dmac_reg_pkg::REG_SRC), 32'hffff_ffff);
      write_reg(reg_addr(2, dmac_reg_pkg::REG_DST), 32'hffff_ffff);
      verify_addr_regs();

      // single copy of 12 beats on channel 0
      start_copy(0, 32'h0000_0000, 32'h0000_0400, 16'd12);
      wait_idle(0);
      scan_memory();

      // both channels at once
      start_copy(0, 32'h0000_0100, 32'h0000_0600, 16'd20);
      start_copy(1, 32'h0000_0200, 32'h0000_0800, 16'd20);
      wait_idle(0);
      wait_idle(1);
      scan_memory();

      // zero length command without memory traffic
      req_before = req_cycles;
      write_reg(reg_addr(1, dmac_reg_pkg::REG_SRC), 32'h0000_0300);
      write_reg(reg_addr(1, dmac_reg_pkg::REG_DST), 32'h0000_0a00);
      write_reg(reg_addr(1, dmac_reg_pkg::REG_CMD), make_cmd(15'h2d00, 1'b1, 16'd0));
      wait_idle(1);
      read_reg(reg_addr(1, dmac_reg_pkg::REG_CMD), rdata);
      expect_word("ch1 REG_CMD", 32'h5a01_0000, rdata);
      expect_word("mem_req_o cycles", req_before, req_cycles);
      scan_memory();

      while (name_q.size() != 0)
         @(negedge clk_dma_i);
      @(negedge clk_dma_i);
      finish_run();
   end

   initial
   begin : watchdog
      wait (cycle_count >= MAX_CYCLES);
      $display("run stopped after %0d cycles without finishing the tests", MAX_CYCLES);
      timeouts = 1;
      finish_run();
   end

endmodule
